// ==== hdl/rob_cfg_pkg.sv ====
`default_nettype none

package rob_cfg_pkg;

    localparam int ROB_DEPTH = 64;  // default entry count
    localparam int ALLOC_W   = 4;   // instructions per allocation group
    localparam int COMMIT_W  = 4;   // max retirements per cycle

    // writeback sources: mult, alu1, alu2, load
    localparam int NUM_CMPL  = 4;

    typedef logic [5:0]  rob_idx_t;    // entry index
    typedef logic [6:0]  rob_ptr_t;    // index plus wrap bit, also holds a count of 64
    typedef logic [5:0]  preg_t;       // physical register number
    typedef logic [15:0] pc_t;

    // compare code from the register file
    // 0 means no result this cycle
    typedef logic [1:0]  brnc_cond_t;

endpackage

`default_nettype wire

// ==== hdl/rob_msg_pkg.sv ====
`default_nettype none

package rob_msg_pkg;

    // one instruction of an allocation group
    typedef struct packed {
        logic                    is_brnc;
        logic                    pred_taken;
        rob_cfg_pkg::brnc_cond_t cond;       // taken when the compare result equals this
        rob_cfg_pkg::pc_t        rcvr_pc;
        logic                    reg_wrt;
        rob_cfg_pkg::preg_t      old_preg;   // freed at commit
    } alloc_slot_t;

    // branch half of an entry
    typedef struct packed {
        logic                    is_brnc;
        logic                    pred_taken;
        rob_cfg_pkg::brnc_cond_t cond;
        rob_cfg_pkg::pc_t        rcvr_pc;
    } brnc_info_t;

    // destination half of an entry
    typedef struct packed {
        logic                    reg_wrt;
        rob_cfg_pkg::preg_t      old_preg;
    } dest_info_t;

    typedef struct packed {
        logic                    vld;
        rob_cfg_pkg::rob_idx_t   idx;
    } cmpl_t;

    typedef struct packed {
        rob_cfg_pkg::rob_idx_t   idx;
        rob_cfg_pkg::brnc_cond_t rslt;       // nonzero for a single cycle
    } resolve_t;

    typedef struct packed {
        logic [2:0]                                     cnt;
        logic [2:0]                                     free_cnt;
        rob_cfg_pkg::preg_t [rob_cfg_pkg::COMMIT_W-1:0] free_preg;
    } commit_t;

endpackage

`default_nettype wire

// ==== hdl/rob_alloc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_alloc_ctrl #(
    parameter int DEPTH   = rob_cfg_pkg::ROB_DEPTH,
    parameter int ALLOC_W = rob_cfg_pkg::ALLOC_W
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        all_nop,
    input  wire                        mis_pred,
    input  wire rob_cfg_pkg::rob_idx_t brnc_idx,
    input  wire rob_cfg_pkg::rob_idx_t head,
    input  wire [2:0]                  cmt_cnt,
    output rob_cfg_pkg::rob_idx_t      tail,
    output logic                       alloc_en,
    output logic                       full,
    output logic                       empty
);
    import rob_cfg_pkg::*;

    rob_ptr_t count;        // occupied entries
    rob_idx_t brnc_span;    // head to branch distance

    assign brnc_span = brnc_idx - head;

    // no room for a whole group
    assign full     = count > rob_ptr_t'(DEPTH - ALLOC_W);
    assign empty    = count == '0;
    assign alloc_en = !all_nop && !full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail  <= '0;
            count <= '0;
        end else if (mis_pred) begin
            // keep head through branch, drop the offered group too
            tail  <= brnc_idx + 1'b1;
            count <= rob_ptr_t'(brnc_span) + 1'b1 - rob_ptr_t'(cmt_cnt);
        end else begin
            if (alloc_en) begin
                tail <= tail + rob_idx_t'(ALLOC_W);
            end
            count <= count + (alloc_en ? rob_ptr_t'(ALLOC_W) : '0) - rob_ptr_t'(cmt_cnt);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_status #(
    parameter int DEPTH   = rob_cfg_pkg::ROB_DEPTH,
    parameter int ALLOC_W = rob_cfg_pkg::ALLOC_W
) (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire                                                 alloc_en,
    input  wire rob_cfg_pkg::rob_idx_t                          tail,
    input  wire rob_msg_pkg::cmpl_t [rob_cfg_pkg::NUM_CMPL-1:0] cmpl,
    input  wire                                                 brnc_ok,
    input  wire                                                 mis_pred,
    input  wire rob_cfg_pkg::rob_idx_t                          brnc_idx,
    input  wire rob_cfg_pkg::rob_idx_t                          head,
    input  wire [2:0]                                           cmt_cnt,
    output logic [DEPTH-1:0]                                    vld,
    output logic [DEPTH-1:0]                                    done
);
    import rob_cfg_pkg::*;

    logic [DEPTH-1:0] set_vld;     // allocated this cycle
    logic [DEPTH-1:0] clr_vld;     // retired or squashed
    logic [DEPTH-1:0] set_done;

    always_comb begin
        rob_idx_t ent;
        rob_idx_t brnc_dist;
        brnc_dist = brnc_idx - head;
        for (int i = 0; i < DEPTH; i++) begin
            ent = rob_idx_t'(i);
            // a mispredict drops the group offered in the same cycle
            set_vld[i] = alloc_en && !mis_pred && (rob_idx_t'(ent - tail) < rob_idx_t'(ALLOC_W));
            // retired range, then anything younger than a bad branch
            clr_vld[i] = (rob_idx_t'(ent - head) < rob_idx_t'(cmt_cnt))
                      || (mis_pred && (rob_idx_t'(ent - head) > brnc_dist));
            // resolved branch is finished either way
            set_done[i] = (brnc_ok || mis_pred) && (ent == brnc_idx);
            for (int s = 0; s < NUM_CMPL; s++) begin
                if (cmpl[s].vld && (cmpl[s].idx == ent)) begin
                    set_done[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld  <= '0;
            done <= '0;
        end else begin
            vld  <= set_vld | (vld & ~clr_vld);
            done <= ~set_vld & (done | set_done);  // fresh entries start not done
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_payload_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_payload_ram #(
    parameter int  DEPTH     = rob_cfg_pkg::ROB_DEPTH,
    parameter int  ALLOC_W   = rob_cfg_pkg::ALLOC_W,
    parameter int  COMMIT_W  = rob_cfg_pkg::COMMIT_W,
    parameter type payload_t = logic
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         wr_en,
    input  wire rob_cfg_pkg::rob_idx_t  wr_base,
    input  wire payload_t [ALLOC_W-1:0] wr_data,
    input  wire rob_cfg_pkg::rob_idx_t  rd_idx,
    output payload_t                    rd_data,
    input  wire rob_cfg_pkg::rob_idx_t  win_base,
    output payload_t [COMMIT_W-1:0]     win_data
);
    import rob_cfg_pkg::*;

    payload_t mem [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            // index wraps with the pointer width
            for (int k = 0; k < ALLOC_W; k++) begin
                mem[rob_idx_t'(wr_base + rob_idx_t'(k))] <= wr_data[k];
            end
        end
    end

    assign rd_data = mem[rd_idx];

    always_comb begin
        for (int k = 0; k < COMMIT_W; k++) begin
            win_data[k] = mem[rob_idx_t'(win_base + rob_idx_t'(k))];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_branch_resolve (
    input  wire rob_msg_pkg::resolve_t   resolve,
    input  wire rob_msg_pkg::brnc_info_t info,
    input  wire                          vld_bit,
    output logic                         mis_pred,
    output logic                         brnc_ok,
    output rob_cfg_pkg::rob_idx_t        brnc_idx,
    output rob_cfg_pkg::pc_t             rcvr_pc
);
    logic act;      // result for a live branch entry
    logic taken;

    assign act   = (resolve.rslt != '0) && vld_bit && info.is_brnc;
    assign taken = resolve.rslt == info.cond;

    // direction disagrees with the stored prediction
    assign mis_pred = act && (taken != info.pred_taken);
    assign brnc_ok  = act && (taken == info.pred_taken);

    assign brnc_idx = resolve.idx;
    assign rcvr_pc  = info.rcvr_pc;   // only meaningful with mis_pred

endmodule

`default_nettype wire

// ==== hdl/rob_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_commit #(
    parameter int DEPTH    = rob_cfg_pkg::ROB_DEPTH,
    parameter int COMMIT_W = rob_cfg_pkg::COMMIT_W
) (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire [DEPTH-1:0]                           vld,
    input  wire [DEPTH-1:0]                           done,
    input  wire rob_msg_pkg::dest_info_t [COMMIT_W-1:0] dest_win,
    output rob_cfg_pkg::rob_idx_t                     head,
    output logic [2:0]                                cmt_cnt,
    output rob_msg_pkg::commit_t                      commit
);
    import rob_cfg_pkg::*;

    // leading run of valid and done entries from the head
    always_comb begin
        logic     run;
        rob_idx_t ent;
        run    = 1'b1;
        commit = '0;
        for (int k = 0; k < COMMIT_W; k++) begin
            ent = head + rob_idx_t'(k);
            run = run && vld[ent] && done[ent];
            if (run) begin
                commit.cnt = commit.cnt + 1'b1;
                if (dest_win[k].reg_wrt) begin
                    // pack freed regs in program order
                    commit.free_preg[commit.free_cnt[1:0]] = dest_win[k].old_preg;
                    commit.free_cnt = commit.free_cnt + 1'b1;
                end
            end
        end
    end

    assign cmt_cnt = commit.cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else begin
            head <= head + rob_idx_t'(commit.cnt);   // wraps at depth
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
    parameter int DEPTH    = rob_cfg_pkg::ROB_DEPTH,
    parameter int ALLOC_W  = rob_cfg_pkg::ALLOC_W,
    parameter int COMMIT_W = rob_cfg_pkg::COMMIT_W
) (
    input  wire                                                    clk,
    input  wire                                                    rst_n,
    input  wire                                                    all_nop,
    input  wire rob_msg_pkg::alloc_slot_t [ALLOC_W-1:0]            alloc,
    input  wire rob_msg_pkg::cmpl_t [rob_cfg_pkg::NUM_CMPL-1:0]    cmpl,
    input  wire rob_msg_pkg::resolve_t                             resolve,
    output rob_cfg_pkg::rob_idx_t                                  next_idx,
    output logic                                                   full,
    output logic                                                   empty,
    output logic                                                   mis_pred,
    output rob_cfg_pkg::pc_t                                       rcvr_pc,
    output rob_msg_pkg::commit_t                                   commit
);
    import rob_cfg_pkg::*;
    import rob_msg_pkg::*;

    rob_idx_t                  tail;
    rob_idx_t                  head;
    rob_idx_t                  brnc_idx;
    logic                      alloc_en;
    logic                      brnc_ok;
    logic [2:0]                cmt_cnt;
    logic [DEPTH-1:0]          vld;
    logic [DEPTH-1:0]          done;
    brnc_info_t                rd_brnc;     // entry under resolution
    brnc_info_t [ALLOC_W-1:0]  brnc_wr;
    dest_info_t [ALLOC_W-1:0]  dest_wr;
    dest_info_t [COMMIT_W-1:0] dest_win;    // head window

    // split each slot into its two storage halves
    always_comb begin
        for (int k = 0; k < ALLOC_W; k++) begin
            brnc_wr[k].is_brnc    = alloc[k].is_brnc;
            brnc_wr[k].pred_taken = alloc[k].pred_taken;
            brnc_wr[k].cond       = alloc[k].cond;
            brnc_wr[k].rcvr_pc    = alloc[k].rcvr_pc;
            dest_wr[k].reg_wrt    = alloc[k].reg_wrt;
            dest_wr[k].old_preg   = alloc[k].old_preg;
        end
    end

    assign next_idx = tail;

    rob_alloc_ctrl #(.DEPTH(DEPTH), .ALLOC_W(ALLOC_W)) u_alloc (
        .clk(clk), .rst_n(rst_n), .all_nop(all_nop), .mis_pred(mis_pred),
        .brnc_idx(brnc_idx), .head(head), .cmt_cnt(cmt_cnt),
        .tail(tail), .alloc_en(alloc_en), .full(full), .empty(empty)
    );

    rob_status #(.DEPTH(DEPTH), .ALLOC_W(ALLOC_W)) u_status (
        .clk(clk), .rst_n(rst_n), .alloc_en(alloc_en), .tail(tail), .cmpl(cmpl),
        .brnc_ok(brnc_ok), .mis_pred(mis_pred), .brnc_idx(brnc_idx),
        .head(head), .cmt_cnt(cmt_cnt), .vld(vld), .done(done)
    );

    rob_payload_ram #(
        .DEPTH(DEPTH), .ALLOC_W(ALLOC_W), .COMMIT_W(COMMIT_W), .payload_t(brnc_info_t)
    ) brnc_ram (
        .clk(clk), .rst_n(rst_n), .wr_en(alloc_en), .wr_base(tail), .wr_data(brnc_wr),
        .rd_idx(resolve.idx), .rd_data(rd_brnc), .win_base(head), .win_data()
    );

    rob_payload_ram #(
        .DEPTH(DEPTH), .ALLOC_W(ALLOC_W), .COMMIT_W(COMMIT_W), .payload_t(dest_info_t)
    ) dest_ram (
        .clk(clk), .rst_n(rst_n), .wr_en(alloc_en), .wr_base(tail), .wr_data(dest_wr),
        .rd_idx(resolve.idx), .rd_data(), .win_base(head), .win_data(dest_win)
    );

    rob_branch_resolve u_resolve (
        .resolve(resolve), .info(rd_brnc), .vld_bit(vld[resolve.idx]),
        .mis_pred(mis_pred), .brnc_ok(brnc_ok), .brnc_idx(brnc_idx), .rcvr_pc(rcvr_pc)
    );

    rob_commit #(.DEPTH(DEPTH), .COMMIT_W(COMMIT_W)) u_commit (
        .clk(clk), .rst_n(rst_n), .vld(vld), .done(done), .dest_win(dest_win),
        .head(head), .cmt_cnt(cmt_cnt), .commit(commit)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rob;
    import rob_cfg_pkg::*;
    import rob_msg_pkg::*;

    typedef struct packed {
        logic [2:0]     test;
        logic [4:0]     rep;      // cycles the row is held
        logic           nop;
        logic [3:0]     br, pred, wr;  // per slot group flags
        logic [3:0]     cv;       // completion strobes
        rob_idx_t [3:0] ci;
        logic           stride;   // indices step by 4 per repeat
        rob_idx_t       ridx;
        brnc_cond_t     rslt;
    } step_t;

    logic clk, rst_n, all_nop, full, empty, mis_pred;
    alloc_slot_t [ALLOC_W-1:0] alloc;
    cmpl_t [NUM_CMPL-1:0]      cmpl;
    resolve_t                  resolve;
    rob_idx_t                  next_idx;
    pc_t                       rcvr_pc;
    commit_t                   commit;

    // reference model state
    step_t       steps[$];
    alloc_slot_t m_slot[ROB_DEPTH];
    logic        m_vld[ROB_DEPTH], m_done[ROB_DEPTH];
    rob_idx_t    m_head, m_tail;
    int          m_count, errors, failed;
    logic        e_mis, e_ok, e_full, e_take;
    commit_t     e_commit;

    rob_top dut0 (.clk(clk), .rst_n(rst_n), .all_nop(all_nop), .alloc(alloc), .cmpl(cmpl),
        .resolve(resolve), .next_idx(next_idx), .full(full), .empty(empty),
        .mis_pred(mis_pred), .rcvr_pc(rcvr_pc), .commit(commit));

    always #10 clk = ~clk;

    task automatic add_row(input int test, rep, nop, input logic [3:0] br, pred, wr, cv,
                           input int c0, c1, c2, c3, stride, ridx, rslt);
        step_t s;
        s = '{test: 3'(test), rep: 5'(rep), nop: 1'(nop), br: br, pred: pred, wr: wr, cv: cv,
              ci: {rob_idx_t'(c3), rob_idx_t'(c2), rob_idx_t'(c1), rob_idx_t'(c0)},
              stride: 1'(stride), ridx: rob_idx_t'(ridx), rslt: brnc_cond_t'(rslt)};
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_row(input step_t s, input int r);
        for (int k = 0; k < ALLOC_W; k++) begin
            alloc[k] = '{is_brnc: s.br[k], pred_taken: s.pred[k], cond: 2'd1,
                         rcvr_pc: pc_t'($urandom), reg_wrt: s.wr[k], old_preg: preg_t'($urandom)};
            cmpl[k].vld = s.cv[k];
            cmpl[k].idx = s.stride ? s.ci[k] + rob_idx_t'(4 * r) : s.ci[k];
        end
        resolve = '{idx: s.ridx, rslt: s.rslt};
        all_nop = s.nop;
    endtask

    // expected outputs from the model state and the inputs of this cycle
    task automatic predict_and_check();
        preg_t    freed[$];
        rob_idx_t e;
        logic     taken, act, run;
        act    = (resolve.rslt != '0) && m_vld[resolve.idx] && m_slot[resolve.idx].is_brnc;
        taken  = resolve.rslt == m_slot[resolve.idx].cond;
        e_mis  = act && (taken != m_slot[resolve.idx].pred_taken);
        e_ok   = act && (taken == m_slot[resolve.idx].pred_taken);
        e_full = (ROB_DEPTH - m_count) < ALLOC_W;  // room for less than a group
        e_take = !all_nop && !e_full && !e_mis;
        e_commit = '0;
        run = 1'b1;
        for (int k = 0; k < COMMIT_W; k++) begin
            e   = m_head + rob_idx_t'(k);
            run = run && m_vld[e] && m_done[e];
            if (run) begin
                e_commit.cnt = e_commit.cnt + 3'd1;
                if (m_slot[e].reg_wrt) freed.push_back(m_slot[e].old_preg);
            end
        end
        foreach (freed[j]) e_commit.free_preg[j] = freed[j];
        e_commit.free_cnt = 3'(freed.size());
        check_value("next_idx", 32'(next_idx), 32'(m_tail));
        check_value("full", 32'(full), 32'(e_full));
        check_value("empty", 32'(empty), 32'(m_count == 0));
        check_value("mis_pred", 32'(mis_pred), 32'(e_mis));
        if (e_mis) check_value("rcvr_pc", 32'(rcvr_pc), 32'(m_slot[resolve.idx].rcvr_pc));
        check_value("commit.cnt", 32'(commit.cnt), 32'(e_commit.cnt));
        check_value("commit.free_cnt", 32'(commit.free_cnt), 32'(e_commit.free_cnt));
        check_value("commit.free_preg", 32'(commit.free_preg), 32'(e_commit.free_preg));
    endtask

    task automatic update_model();
        rob_idx_t e;
        for (int k = 0; k < int'(e_commit.cnt); k++) m_vld[m_head + rob_idx_t'(k)] = 1'b0;
        if (e_ok || e_mis) m_done[resolve.idx] = 1'b1;
        if (e_mis) begin
            e = resolve.idx + 1'b1;
            for (int n = 0; n < ROB_DEPTH && e != m_tail; n++) begin  // squash younger
                m_vld[e] = 1'b0;
                e = e + 1'b1;
            end
            m_tail = resolve.idx + 1'b1;
        end
        for (int k = 0; k < NUM_CMPL; k++) if (cmpl[k].vld) m_done[cmpl[k].idx] = 1'b1;
        if (e_take) begin
            for (int k = 0; k < ALLOC_W; k++) begin
                e = m_tail + rob_idx_t'(k);
                m_slot[e] = alloc[k];
                m_vld[e]  = 1'b1;
                m_done[e] = 1'b0;
            end
            m_tail = m_tail + rob_idx_t'(ALLOC_W);
        end
        m_head  = m_head + rob_idx_t'(e_commit.cnt);
        m_count = 0;
        foreach (m_vld[i]) m_count += int'(m_vld[i]);
    endtask

    initial begin
        step_t s;
        int    mark, n;
        void'($urandom(20));
        clk = 0;
        rst_n = 0;
        all_nop = 1;
        alloc = '0;
        cmpl = '0;
        resolve = '0;
        errors = 0;
        failed = 0;
        mark = 0;
        m_head = '0;
        m_tail = '0;
        m_count = 0;
        foreach (m_vld[i]) begin
            m_vld[i] = 1'b0;
            m_done[i] = 1'b0;
            m_slot[i] = '0;
        end
        // test rep nop br pred wr cv c0 c1 c2 c3 stride ridx rslt
        add_row(1, 2, 1, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, 8, 0, 4'h0, 4'h0, 4'hb, 4'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(2, 8, 0, 4'h4, 4'h4, 4'hb, 4'h0, 0, 0, 0, 0, 0, 0, 0);  // branch in slot 2
        add_row(2, 3, 0, 4'h0, 4'h0, 4'hf, 4'h0, 0, 0, 0, 0, 0, 0, 0);  // offered while full
        add_row(3, 1, 1, 4'h0, 4'h0, 4'h0, 4'h7, 2, 1, 3, 0, 0, 0, 0);
        add_row(3, 1, 1, 4'h0, 4'h0, 4'h0, 4'h1, 0, 0, 0, 0, 0, 0, 0);
        add_row(3, 1, 1, 4'h0, 4'h0, 4'h0, 4'h7, 5, 6, 7, 0, 0, 0, 0);
        add_row(3, 1, 1, 4'h0, 4'h0, 4'h0, 4'h1, 4, 0, 0, 0, 0, 0, 0);
        add_row(3, 2, 1, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(4, 6, 1, 4'h0, 4'h0, 4'h0, 4'hf, 8, 9, 10, 11, 1, 0, 0);
        add_row(4, 1, 1, 4'h0, 4'h0, 4'h0, 4'h3, 32, 33, 0, 0, 0, 34, 1);  // taken as predicted
        add_row(4, 1, 1, 4'h0, 4'h0, 4'h0, 4'h1, 35, 0, 0, 0, 0, 0, 0);
        add_row(4, 3, 1, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(5, 1, 0, 4'h0, 4'h0, 4'hf, 4'h0, 0, 0, 0, 0, 0, 38, 2);  // not taken, mispredict
        add_row(5, 1, 1, 4'h0, 4'h0, 4'h0, 4'hf, 36, 37, 39, 40, 0, 0, 0);
        add_row(5, 3, 1, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(6, 1, 0, 4'h0, 4'h0, 4'h6, 4'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(6, 1, 1, 4'h0, 4'h0, 4'h0, 4'hf, 39, 40, 41, 42, 0, 0, 0);
        add_row(6, 2, 1, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 0, 0);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1;
        foreach (steps[i]) begin
            s = steps[i];
            for (int r = 0; r < int'(s.rep); r++) begin
                @(negedge clk);
                drive_row(s, r);
                #1 predict_and_check();
                @(posedge clk);
                update_model();
            end
            if (i == steps.size() - 1 || steps[i + 1].test != s.test) begin
                $display("test %0d: %s", s.test, (errors == mark) ? "ok" : "failed");
                if (errors != mark) failed++;
                mark = errors;
            end
        end
        n = 0;
        @(negedge clk);
        while (!empty && n < 20) begin  // drain with a bound
            @(negedge clk);
            n++;
        end
        if (!empty) begin
            $display("timeout: the buffer did not become empty within 20 cycles");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            $display("tests run 6, failed %0d, errors %0d", failed, errors);
            if (errors == 0) $display("Simulation finished: PASS");
            else $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rob4.f ====
hdl/rob_cfg_pkg.sv
hdl/rob_msg_pkg.sv
hdl/rob_alloc_ctrl.sv
hdl/rob_status.sv
hdl/rob_payload_ram.sv
hdl/rob_branch_resolve.sv
hdl/rob_commit.sv
hdl/rob_top.sv
testbench/tb_rob.sv

// ==== Makefile ====
TOP = tb_rob

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f rob4.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
